// File: sources.f
+incdir+verification
verilog/rucklidge_pkg.sv
verilog/rucklidge_linear_terms.sv
verilog/rucklidge_product_terms.sv
verilog/rucklidge_integrator.sv
verilog/rucklidge_sequencer.sv
verilog/rucklidge_axil_regs.sv
verilog/rucklidge_top.sv
verification/rucklidge_tb.sv

// File: Bender.yml
package:
  name: rucklidge

sources:
  - verilog/rucklidge_pkg.sv
  - verilog/rucklidge_linear_terms.sv
  - verilog/rucklidge_product_terms.sv
  - verilog/rucklidge_integrator.sv
  - verilog/rucklidge_sequencer.sv
  - verilog/rucklidge_axil_regs.sv
  - verilog/rucklidge_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/rucklidge_tb.sv

// File: verification/rucklidge_tb_axil.svh
// ##############################
// axi4-lite master and compare tasks
// tasks start and end on a falling edge
// ##############################
`ifndef RUCKLIDGE_TB_AXIL_SVH
`define RUCKLIDGE_TB_AXIL_SVH

localparam int hs_timeout = 20;

task automatic write_reg(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                         output resp_e resp);
  int cnt;
  awaddr  = addr;
  awvalid = 1'b1;
  wdata   = data;
  wvalid  = 1'b1;
  cnt     = 0;
  while (!(awready && wready)) begin
    @(negedge clk);
    cnt++;
    if (cnt > hs_timeout) fail_run("timeout waiting for awready and wready");
  end
  // handshake completes on the coming rising edge
  @(negedge clk);
  awvalid = 1'b0;
  wvalid  = 1'b0;
  bready  = 1'b1;
  cnt     = 0;
  while (!bvalid) begin
    @(negedge clk);
    cnt++;
    if (cnt > hs_timeout) fail_run("timeout waiting for bvalid");
  end
  resp = bresp;
  @(negedge clk);
  bready = 1'b0;
endtask

task automatic read_reg(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data,
                        output resp_e resp);
  int cnt;
  araddr  = addr;
  arvalid = 1'b1;
  cnt     = 0;
  while (!arready) begin
    @(negedge clk);
    cnt++;
    if (cnt > hs_timeout) fail_run("timeout waiting for arready");
  end
  @(negedge clk);
  arvalid = 1'b0;
  rready  = 1'b1;
  cnt     = 0;
  while (!rvalid) begin
    @(negedge clk);
    cnt++;
    if (cnt > hs_timeout) fail_run("timeout waiting for rvalid");
  end
  data = rdata;
  resp = rresp;
  @(negedge clk);
  rready = 1'b0;
endtask

task automatic check_fix(input string name, input fix_t exp, input fix_t act);
  if (act !== exp) begin
    fail_run($sformatf("error at %0t: %s expected %h actual %h", $time, name, exp, act));
  end
endtask

task automatic check_word(input string name, input logic [data_w-1:0] exp,
                          input logic [data_w-1:0] act);
  if (act !== exp) begin
    fail_run($sformatf("error at %0t: %s expected %h actual %h", $time, name, exp, act));
  end
endtask

task automatic check_resp(input string name, input resp_e exp, input resp_e act);
  if (act !== exp) begin
    fail_run($sformatf("error at %0t: %s expected %0d actual %0d", $time, name, exp, act));
  end
endtask

`endif

// File: verification/rucklidge_tb.sv
// ##############################
// inputs driven on the falling edge
// expected state from a euler model
// built on the package arithmetic
// ##############################
module rucklidge_tb import rucklidge_pkg::*; ();

  typedef struct packed {
    fix_t              a;
    fix_t              b;
    fix_t              h;
    fix_t              x0;
    fix_t              y0;
    fix_t              z0;
    logic [data_w-1:0] steps;
    logic              sat;
  } row_t;

  localparam int n_rows = 4;

  // a, b, h, x0, y0, z0, steps, saturating
  row_t rows [n_rows] = '{
    '{32'h0020_0000, 32'h006B_3333, 32'h0000_4000,
      32'h0010_0000, 32'h0000_0000, 32'h0048_0000, 32'd50, 1'b0},
    '{32'h0020_0000, 32'h006B_3333, 32'h0010_0000,
      32'h4000_0000, 32'h4000_0000, 32'h4000_0000, 32'd2, 1'b1},
    '{32'h0020_0000, 32'h006B_3333, 32'h0000_4000,
      32'hFFF8_0000, 32'h0004_0000, 32'h0010_0000, 32'd0, 1'b0},
    '{32'h0010_0000, 32'h0030_0000, 32'h0000_8000,
      32'h0008_0000, 32'hFFF0_0000, 32'h0020_0000, 32'd17, 1'b0}
  };

  reg_addr_e param_regs [7] = '{reg_steps, reg_coef_a, reg_coef_b, reg_step_h,
                                reg_init_x, reg_init_y, reg_init_z};

  logic                clk;
  logic                reset;
  logic [addr_w-1:0]   awaddr;
  logic                awvalid;
  logic                awready;
  logic [data_w-1:0]   wdata;
  logic [data_w/8-1:0] wstrb;
  logic                wvalid;
  logic                wready;
  resp_e               bresp;
  logic                bvalid;
  logic                bready;
  logic [addr_w-1:0]   araddr;
  logic                arvalid;
  logic                arready;
  logic [data_w-1:0]   rdata;
  resp_e               rresp;
  logic                rvalid;
  logic                rready;
  logic                done;
  logic [15:0]         lfsr_q;

  rucklidge_top UUT (
    .clk_i(clk), .reset_i(reset),
    .s_awaddr_i(awaddr), .s_awvalid_i(awvalid), .s_awready_o(awready),
    .s_wdata_i(wdata), .s_wstrb_i(wstrb), .s_wvalid_i(wvalid), .s_wready_o(wready),
    .s_bresp_o(bresp), .s_bvalid_o(bvalid), .s_bready_i(bready),
    .s_araddr_i(araddr), .s_arvalid_i(arvalid), .s_arready_o(arready),
    .s_rdata_o(rdata), .s_rresp_o(rresp), .s_rvalid_o(rvalid), .s_rready_i(rready),
    .done_o(done)
  );

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  `include "rucklidge_tb_axil.svh"

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [data_w-1:0] take_bits(input int n);
    logic [data_w-1:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[data_w-2:0], lfsr_q[0]};
    end
    return val;
  endfunction

  // all three updates read the old state
  task automatic euler_model(input row_t r, output fix_t xo, output fix_t yo,
                             output fix_t zo);
    fix_t x;
    fix_t y;
    fix_t z;
    fix_t dx;
    fix_t dz;
    fix_t xn;
    x = r.x0;
    y = r.y0;
    z = r.z0;
    for (int unsigned i = 0; i < r.steps; i++) begin
      dx = fix_sub(fix_sub(fix_mul(r.b, y), fix_mul(r.a, x)), fix_mul(y, z));
      dz = fix_sub(fix_mul(y, y), z);
      xn = fix_add(x, fix_mul(r.h, dx));
      y  = fix_add(y, fix_mul(r.h, x));
      z  = fix_add(z, fix_mul(r.h, dz));
      x  = xn;
    end
    xo = x;
    yo = y;
    zo = z;
  endtask

  task automatic write_checked(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                               input resp_e exp);
    resp_e resp;
    write_reg(addr, data, resp);
    check_resp($sformatf("bresp at %h", addr), exp, resp);
  endtask

  task automatic read_checked(input logic [addr_w-1:0] addr, input resp_e exp,
                              output logic [data_w-1:0] data);
    resp_e resp;
    read_reg(addr, data, resp);
    check_resp($sformatf("rresp at %h", addr), exp, resp);
  endtask

  task automatic wait_done(input logic [data_w-1:0] steps);
    int cnt;
    int limit;
    limit = 2 + 2 * steps + 8;
    cnt   = 0;
    while (!done) begin
      @(negedge clk);
      cnt++;
      if (cnt > limit) fail_run("timeout waiting for done_o");
    end
  endtask

  task automatic load_params(input row_t r);
    write_checked(reg_coef_a, r.a, resp_okay);
    write_checked(reg_coef_b, r.b, resp_okay);
    write_checked(reg_step_h, r.h, resp_okay);
    write_checked(reg_init_x, r.x0, resp_okay);
    write_checked(reg_init_y, r.y0, resp_okay);
    write_checked(reg_init_z, r.z0, resp_okay);
    write_checked(reg_steps, r.steps, resp_okay);
  endtask

  task automatic check_result(input row_t r);
    fix_t              ex;
    fix_t              ey;
    fix_t              ez;
    logic [data_w-1:0] data;
    euler_model(r, ex, ey, ez);
    read_checked(reg_state_x, resp_okay, data);
    check_fix("state_x", ex, data);
    read_checked(reg_state_y, resp_okay, data);
    check_fix("state_y", ey, data);
    read_checked(reg_state_z, resp_okay, data);
    check_fix("state_z", ez, data);
    read_checked(reg_step_count, resp_okay, data);
    check_word("step_count", r.steps, data);
    // done set, busy clear
    read_checked(reg_status, resp_okay, data);
    check_word("status", 32'd2, data);
    if (r.sat && !(ex == fix_max || ex == fix_min || ey == fix_max ||
                   ey == fix_min || ez == fix_max || ez == fix_min)) begin
      fail_run("saturation row finished without any state at a bound");
    end
  endtask

  task automatic run_row(input row_t r);
    load_params(r);
    write_checked(reg_ctrl, 32'd1, resp_okay);
    wait_done(r.steps);
    check_result(r);
  endtask

  // parameter write and second start during a run
  task automatic busy_run(input row_t r);
    logic [data_w-1:0] data;
    logic [data_w-1:0] cycles;
    time               t_start;
    r.steps = 40;
    load_params(r);
    write_checked(reg_ctrl, 32'd1, resp_okay);
    t_start = $time;
    read_checked(reg_status, resp_okay, data);
    check_word("status", 32'd1, data);
    write_checked(reg_coef_a, 32'h0123_4567, resp_slverr);
    read_checked(reg_coef_a, resp_okay, data);
    check_fix("coef_a", r.a, data);
    write_checked(reg_ctrl, 32'd1, resp_okay);
    wait_done(r.steps);
    // write_reg returns 1.5 cycles after the handshake edge
    // and done_o is seen half a cycle after it rises
    cycles = data_w'(($time - t_start) / 40);
    check_word("cycles to done_o", 2 + 2 * r.steps - 1, cycles);
    check_result(r);
  endtask

  task automatic reset_checks();
    logic [data_w-1:0] data;
    check_word("done_o", '0, {{(data_w-1){1'b0}}, done});
    read_checked(reg_status, resp_okay, data);
    check_word("status", '0, data);
    read_checked(reg_step_count, resp_okay, data);
    check_word("step_count", '0, data);
    read_checked(reg_state_x, resp_okay, data);
    check_fix("state_x", '0, data);
    read_checked(reg_state_y, resp_okay, data);
    check_fix("state_y", '0, data);
    read_checked(reg_state_z, resp_okay, data);
    check_fix("state_z", '0, data);
  endtask

  task automatic readback_checks();
    logic [data_w-1:0] data;
    logic [data_w-1:0] pattern;
    for (int i = 0; i < 7; i++) begin
      pattern = {param_regs[i], ~param_regs[i], param_regs[i] ^ 8'h5A, 8'hC3};
      write_checked(param_regs[i], pattern, resp_okay);
      read_checked(param_regs[i], resp_okay, data);
      check_word($sformatf("readback at %h", param_regs[i]), pattern, data);
    end
    read_checked(8'h34, resp_slverr, data);
    read_checked(8'hFC, resp_slverr, data);
    write_checked(8'h40, 32'h1, resp_slverr);
    write_checked(reg_status, 32'h3, resp_slverr);
    write_checked(reg_state_x, 32'h1, resp_slverr);
    write_checked(reg_state_z, 32'h1, resp_slverr);
    write_checked(reg_step_count, 32'h1, resp_slverr);
  endtask

  initial begin
    row_t              r;
    logic [data_w-1:0] bits;
    reset   = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '1;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    lfsr_q  = 16'd48815;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    reset_checks();
    readback_checks();
    for (int k = 0; k < n_rows; k++) begin
      run_row(rows[k]);
    end
    busy_run(rows[0]);
    // random start points within +-8.0
    for (int k = 0; k < 2; k++) begin
      r     = rows[0];
      bits  = take_bits(24);
      r.x0  = {{8{bits[23]}}, bits[23:0]};
      bits  = take_bits(24);
      r.y0  = {{8{bits[23]}}, bits[23:0]};
      bits  = take_bits(24);
      r.z0  = {{8{bits[23]}}, bits[23:0]};
      r.steps = 30;
      run_row(r);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: verilog/rucklidge_top.sv
// ##############################
// rucklidge oscillator behind axi4-lite
// done_o stays high until the next start
// ##############################
module rucklidge_top import rucklidge_pkg::*; (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic [addr_w-1:0]   s_awaddr_i,
  input  logic                s_awvalid_i,
  output logic                s_awready_o,
  input  logic [data_w-1:0]   s_wdata_i,
  input  logic [data_w/8-1:0] s_wstrb_i,
  input  logic                s_wvalid_i,
  output logic                s_wready_o,
  output resp_e               s_bresp_o,
  output logic                s_bvalid_o,
  input  logic                s_bready_i,
  input  logic [addr_w-1:0]   s_araddr_i,
  input  logic                s_arvalid_i,
  output logic                s_arready_o,
  output logic [data_w-1:0]   s_rdata_o,
  output resp_e               s_rresp_o,
  output logic                s_rvalid_o,
  input  logic                s_rready_i,
  output logic                done_o
);

  logic              start_pulse;
  logic [data_w-1:0] steps;
  logic [data_w-1:0] step_count;
  logic              load_en;
  logic              terms_en;
  logic              update_en;
  logic              busy;
  logic              done;
  fix_t              coef_a;
  fix_t              coef_b;
  fix_t              step_h;
  fix_t              init_x;
  fix_t              init_y;
  fix_t              init_z;
  fix_t              x;
  fix_t              y;
  fix_t              z;
  fix_t              lin_x;
  fix_t              lin_z;
  fix_t              prod_yz;
  fix_t              prod_yy;

  rucklidge_axil_regs u_regs (
    .clk_i, .reset_i,
    .s_awaddr_i, .s_awvalid_i, .s_awready_o, .s_wdata_i, .s_wstrb_i, .s_wvalid_i,
    .s_wready_o, .s_bresp_o, .s_bvalid_o, .s_bready_i, .s_araddr_i, .s_arvalid_i,
    .s_arready_o, .s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
    .start_o(start_pulse), .steps_o(steps), .coef_a_o(coef_a), .coef_b_o(coef_b),
    .step_h_o(step_h), .init_x_o(init_x), .init_y_o(init_y), .init_z_o(init_z),
    .busy_i(busy), .done_i(done), .x_i(x), .y_i(y), .z_i(z), .step_count_i(step_count)
  );

  rucklidge_sequencer u_seq (
    .clk_i, .reset_i, .start_i(start_pulse), .steps_i(steps),
    .load_en_o(load_en), .terms_en_o(terms_en), .update_en_o(update_en),
    .busy_o(busy), .done_o(done), .step_count_o(step_count)
  );

  rucklidge_linear_terms u_lin (
    .clk_i, .reset_i, .terms_en_i(terms_en), .coef_a_i(coef_a), .coef_b_i(coef_b),
    .x_i(x), .y_i(y), .z_i(z), .lin_x_o(lin_x), .lin_z_o(lin_z)
  );

  rucklidge_product_terms u_prod (
    .clk_i, .reset_i, .terms_en_i(terms_en), .y_i(y), .z_i(z),
    .prod_yz_o(prod_yz), .prod_yy_o(prod_yy)
  );

  rucklidge_integrator u_int (
    .clk_i, .reset_i, .load_en_i(load_en), .update_en_i(update_en), .step_h_i(step_h),
    .init_x_i(init_x), .init_y_i(init_y), .init_z_i(init_z),
    .lin_x_i(lin_x), .lin_z_i(lin_z), .prod_yz_i(prod_yz), .prod_yy_i(prod_yy),
    .x_o(x), .y_o(y), .z_o(z)
  );

  assign done_o = done;

endmodule

// File: verilog/rucklidge_axil_regs.sv
// ##############################
// axi4-lite slave, one transaction per channel at a time
// wstrb ignored, words are always written whole
// parameter writes while busy get slverr
// ##############################
module rucklidge_axil_regs import rucklidge_pkg::*; (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic [addr_w-1:0]   s_awaddr_i,
  input  logic                s_awvalid_i,
  output logic                s_awready_o,
  input  logic [data_w-1:0]   s_wdata_i,
  input  logic [data_w/8-1:0] s_wstrb_i,
  input  logic                s_wvalid_i,
  output logic                s_wready_o,
  output resp_e               s_bresp_o,
  output logic                s_bvalid_o,
  input  logic                s_bready_i,
  input  logic [addr_w-1:0]   s_araddr_i,
  input  logic                s_arvalid_i,
  output logic                s_arready_o,
  output logic [data_w-1:0]   s_rdata_o,
  output resp_e               s_rresp_o,
  output logic                s_rvalid_o,
  input  logic                s_rready_i,
  output logic                start_o,
  output logic [data_w-1:0]   steps_o,
  output fix_t                coef_a_o,
  output fix_t                coef_b_o,
  output fix_t                step_h_o,
  output fix_t                init_x_o,
  output fix_t                init_y_o,
  output fix_t                init_z_o,
  input  logic                busy_i,
  input  logic                done_i,
  input  fix_t                x_i,
  input  fix_t                y_i,
  input  fix_t                z_i,
  input  logic [data_w-1:0]   step_count_i
);

  logic              wr_ready_q;
  logic              rd_ready_q;
  logic              wr_hs;
  logic              rd_hs;
  logic              bvalid_q;
  logic              rvalid_q;
  resp_e             bresp_q;
  resp_e             rresp_q;
  logic [data_w-1:0] rdata_q;
  logic              start_q;
  logic [data_w-1:0] steps_q;
  fix_t              coef_a_q;
  fix_t              coef_b_q;
  fix_t              step_h_q;
  fix_t              init_x_q;
  fix_t              init_y_q;
  fix_t              init_z_q;

  assign wr_hs = wr_ready_q && s_awvalid_i && s_wvalid_i;
  assign rd_hs = rd_ready_q && s_arvalid_i;

  // write channel
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ready_q <= 1'b0;
      bvalid_q   <= 1'b0;
      bresp_q    <= resp_okay;
      start_q    <= 1'b0;
      steps_q    <= '0;
      coef_a_q   <= '0;
      coef_b_q   <= '0;
      step_h_q   <= '0;
      init_x_q   <= '0;
      init_y_q   <= '0;
      init_z_q   <= '0;
    end else begin
      start_q    <= 1'b0;
      wr_ready_q <= !wr_ready_q && !bvalid_q && s_awvalid_i && s_wvalid_i;
      if (bvalid_q && s_bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (wr_hs) begin
        bvalid_q <= 1'b1;
        bresp_q  <= resp_okay;
        case (s_awaddr_i)
          reg_ctrl: start_q <= s_wdata_i[0] && !busy_i;
          reg_steps, reg_coef_a, reg_coef_b, reg_step_h,
          reg_init_x, reg_init_y, reg_init_z: begin
            if (busy_i) begin
              bresp_q <= resp_slverr;
            end else begin
              case (s_awaddr_i)
                reg_steps:  steps_q  <= s_wdata_i;
                reg_coef_a: coef_a_q <= s_wdata_i;
                reg_coef_b: coef_b_q <= s_wdata_i;
                reg_step_h: step_h_q <= s_wdata_i;
                reg_init_x: init_x_q <= s_wdata_i;
                reg_init_y: init_y_q <= s_wdata_i;
                default:    init_z_q <= s_wdata_i;
              endcase
            end
          end
          // read-only and unmapped
          default: bresp_q <= resp_slverr;
        endcase
      end
    end
  end

  // read channel
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ready_q <= 1'b0;
      rvalid_q   <= 1'b0;
      rresp_q    <= resp_okay;
      rdata_q    <= '0;
    end else begin
      rd_ready_q <= !rd_ready_q && !rvalid_q && s_arvalid_i;
      if (rvalid_q && s_rready_i) begin
        rvalid_q <= 1'b0;
      end
      if (rd_hs) begin
        rvalid_q <= 1'b1;
        rresp_q  <= resp_okay;
        case (s_araddr_i)
          reg_ctrl:       rdata_q <= '0;
          reg_status:     rdata_q <= {{(data_w-2){1'b0}}, done_i, busy_i};
          reg_steps:      rdata_q <= steps_q;
          reg_coef_a:     rdata_q <= coef_a_q;
          reg_coef_b:     rdata_q <= coef_b_q;
          reg_step_h:     rdata_q <= step_h_q;
          reg_init_x:     rdata_q <= init_x_q;
          reg_init_y:     rdata_q <= init_y_q;
          reg_init_z:     rdata_q <= init_z_q;
          reg_state_x:    rdata_q <= x_i;
          reg_state_y:    rdata_q <= y_i;
          reg_state_z:    rdata_q <= z_i;
          reg_step_count: rdata_q <= step_count_i;
          default: begin
            rdata_q <= '0;
            rresp_q <= resp_slverr;
          end
        endcase
      end
    end
  end

  assign s_awready_o = wr_ready_q;
  assign s_wready_o  = wr_ready_q;
  assign s_bvalid_o  = bvalid_q;
  assign s_bresp_o   = bresp_q;
  assign s_arready_o = rd_ready_q;
  assign s_rvalid_o  = rvalid_q;
  assign s_rresp_o   = rresp_q;
  assign s_rdata_o   = rdata_q;

  assign start_o  = start_q;
  assign steps_o  = steps_q;
  assign coef_a_o = coef_a_q;
  assign coef_b_o = coef_b_q;
  assign step_h_o = step_h_q;
  assign init_x_o = init_x_q;
  assign init_y_o = init_y_q;
  assign init_z_o = init_z_q;

  a_bvalid_hold: assert property (
    @(posedge clk_i) disable iff (reset_i) (s_bvalid_o && !s_bready_i) |=> s_bvalid_o
  );

endmodule

// File: verilog/rucklidge_sequencer.sv
// ##############################
// one step in flight, terms then update
// start to done is 2 + 2*steps cycles
// ##############################
module rucklidge_sequencer import rucklidge_pkg::*; (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              start_i,
  input  logic [data_w-1:0] steps_i,
  output logic              load_en_o,
  output logic              terms_en_o,
  output logic              update_en_o,
  output logic              busy_o,
  output logic              done_o,
  output logic [data_w-1:0] step_count_o
);

  seq_state_e        state_q;
  logic              busy_q;
  logic              done_q;
  logic [data_w-1:0] count_q;
  logic [data_w-1:0] count_inc;

  assign count_inc = count_q + 1'b1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= seq_idle;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      count_q <= '0;
    end else begin
      case (state_q)
        seq_idle: begin
          if (start_i) begin
            state_q <= seq_load;
            busy_q  <= 1'b1;
            done_q  <= 1'b0;
          end
        end
        seq_load: begin
          count_q <= '0;
          if (steps_i == '0) begin
            state_q <= seq_finish;
            busy_q  <= 1'b0;
            done_q  <= 1'b1;
          end else begin
            state_q <= seq_terms;
          end
        end
        seq_terms: state_q <= seq_update;
        seq_update: begin
          count_q <= count_inc;
          if (count_inc == steps_i) begin
            state_q <= seq_finish;
            busy_q  <= 1'b0;
            done_q  <= 1'b1;
          end else begin
            state_q <= seq_terms;
          end
        end
        seq_finish: state_q <= seq_idle;
        default: state_q <= seq_idle;
      endcase
    end
  end

  assign load_en_o    = (state_q == seq_load);
  assign terms_en_o   = (state_q == seq_terms);
  assign update_en_o  = (state_q == seq_update);
  assign busy_o       = busy_q;
  assign done_o       = done_q;
  assign step_count_o = count_q;

  a_terms_update_excl: assert property (
    @(posedge clk_i) disable iff (reset_i) !(terms_en_o && update_en_o)
  );

  // start pulses only reach an idle sequencer
  a_start_ignored_busy: assert property (
    @(posedge clk_i) disable iff (reset_i) start_i |-> (state_q == seq_idle)
  );

endmodule

// File: verilog/rucklidge_integrator.sv
// ##############################
// explicit euler update of x, y, z
// terms must be latched from the same state the update reads
// ##############################
module rucklidge_integrator import rucklidge_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,
  input  logic load_en_i,
  input  logic update_en_i,
  input  fix_t step_h_i,
  input  fix_t init_x_i,
  input  fix_t init_y_i,
  input  fix_t init_z_i,
  input  fix_t lin_x_i,
  input  fix_t lin_z_i,
  input  fix_t prod_yz_i,
  input  fix_t prod_yy_i,
  output fix_t x_o,
  output fix_t y_o,
  output fix_t z_o
);

  fix_t x_q;
  fix_t y_q;
  fix_t z_q;
  fix_t dx;
  fix_t dy;
  fix_t dz;
  fix_t x_next;
  fix_t y_next;
  fix_t z_next;

  // derivatives from registered terms
  assign dx = fix_sub(lin_x_i, prod_yz_i);
  assign dy = x_q;
  assign dz = fix_add(prod_yy_i, lin_z_i);

  assign x_next = fix_add(x_q, fix_mul(step_h_i, dx));
  assign y_next = fix_add(y_q, fix_mul(step_h_i, dy));
  assign z_next = fix_add(z_q, fix_mul(step_h_i, dz));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      x_q <= '0;
      y_q <= '0;
      z_q <= '0;
    end else if (load_en_i) begin
      x_q <= init_x_i;
      y_q <= init_y_i;
      z_q <= init_z_i;
    end else if (update_en_i) begin
      x_q <= x_next;
      y_q <= y_next;
      z_q <= z_next;
    end
  end

  assign x_o = x_q;
  assign y_o = y_q;
  assign z_o = z_q;

  // sequencer must never overlap a load with an update
  a_load_update_excl: assert property (
    @(posedge clk_i) disable iff (reset_i) !(load_en_i && update_en_i)
  );

endmodule

// File: verilog/rucklidge_product_terms.sv
// ##############################
// nonlinear products y*z and y*y
// both saturated, latched on terms_en
// ##############################
module rucklidge_product_terms import rucklidge_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,
  input  logic terms_en_i,
  input  fix_t y_i,
  input  fix_t z_i,
  output fix_t prod_yz_o,
  output fix_t prod_yy_o
);

  fix_t yz_d;
  fix_t yy_d;
  fix_t yz_q;
  fix_t yy_q;

  // two multipliers side by side with the linear unit
  assign yz_d = fix_mul(y_i, z_i);
  assign yy_d = fix_mul(y_i, y_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      yz_q <= '0;
      yy_q <= '0;
    end else if (terms_en_i) begin
      yz_q <= yz_d;
      yy_q <= yy_d;
    end
  end

  assign prod_yz_o = yz_q;
  assign prod_yy_o = yy_q;

endmodule

// File: verilog/rucklidge_linear_terms.sv
// ##############################
// linear derivative parts, latched on terms_en
// the y derivative needs no term here
// ##############################
module rucklidge_linear_terms import rucklidge_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,
  input  logic terms_en_i,
  input  fix_t coef_a_i,
  input  fix_t coef_b_i,
  input  fix_t x_i,
  input  fix_t y_i,
  input  fix_t z_i,
  output fix_t lin_x_o,
  output fix_t lin_z_o
);

  fix_t by;
  fix_t ax;
  fix_t lin_x_d;
  fix_t lin_z_d;
  fix_t lin_x_q;
  fix_t lin_z_q;

  assign by      = fix_mul(coef_b_i, y_i);
  assign ax      = fix_mul(coef_a_i, x_i);
  assign lin_x_d = fix_sub(by, ax);
  // saturating negate, -min clamps to max
  assign lin_z_d = fix_sub(fix_t'(0), z_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lin_x_q <= '0;
      lin_z_q <= '0;
    end else if (terms_en_i) begin
      lin_x_q <= lin_x_d;
      lin_z_q <= lin_z_d;
    end
  end

  assign lin_x_o = lin_x_q;
  assign lin_z_o = lin_z_q;

endmodule

// File: verilog/rucklidge_pkg.sv
// ##############################
// signed q11.20 fixed point, products truncated toward -inf
// every mul, add and sub saturates to the 32-bit range
// ##############################
package rucklidge_pkg;

  localparam int data_w = 32;
  localparam int frac_w = 20;
  localparam int addr_w = 8;

  typedef logic signed [data_w-1:0] fix_t;

  localparam fix_t fix_max = {1'b0, {(data_w-1){1'b1}}};
  localparam fix_t fix_min = {1'b1, {(data_w-1){1'b0}}};

  // byte addresses, word aligned
  typedef enum logic [addr_w-1:0] {
    reg_ctrl       = 8'h00,
    reg_status     = 8'h04,
    reg_steps      = 8'h08,
    reg_coef_a     = 8'h0C,
    reg_coef_b     = 8'h10,
    reg_step_h     = 8'h14,
    reg_init_x     = 8'h18,
    reg_init_y     = 8'h1C,
    reg_init_z     = 8'h20,
    reg_state_x    = 8'h24,
    reg_state_y    = 8'h28,
    reg_state_z    = 8'h2C,
    reg_step_count = 8'h30
  } reg_addr_e;

  typedef enum logic [2:0] {
    seq_idle,
    seq_load,
    seq_terms,
    seq_update,
    seq_finish
  } seq_state_e;

  typedef enum logic [1:0] {
    resp_okay   = 2'd0,
    resp_slverr = 2'd2
  } resp_e;

  function automatic fix_t fix_mul(fix_t a, fix_t b);
    logic signed [2*data_w-1:0] prod;
    logic signed [2*data_w-1:0] scaled;
    prod   = a * b;
    scaled = prod >>> frac_w;
    if (scaled > fix_max) return fix_max;
    if (scaled < fix_min) return fix_min;
    return scaled[data_w-1:0];
  endfunction

  function automatic fix_t fix_add(fix_t a, fix_t b);
    logic signed [data_w:0] sum;
    sum = a + b;
    if (sum > fix_max) return fix_max;
    if (sum < fix_min) return fix_min;
    return sum[data_w-1:0];
  endfunction

  function automatic fix_t fix_sub(fix_t a, fix_t b);
    logic signed [data_w:0] diff;
    diff = a - b;
    if (diff > fix_max) return fix_max;
    if (diff < fix_min) return fix_min;
    return diff[data_w-1:0];
  endfunction

endpackage
